// ==== verilog/spi_pkg.sv ====
// SPI controller shared types
package spi_pkg;

    // width of the count field in fifo status
    localparam int MAX_CNT_W = 8;

    // register byte offsets
    localparam logic [7:0] REG_TXDATA   = 8'h00;
    localparam logic [7:0] REG_RXDATA   = 8'h04;
    localparam logic [7:0] REG_STATUS   = 8'h08;
    localparam logic [7:0] REG_IRQ_EN   = 8'h0C;
    localparam logic [7:0] REG_IRQ_PEND = 8'h10;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // STATUS layout, upper bits read as zero
    //   bit 0 tx_empty, bit 1 tx_full, bit 2 rx_empty, bit 3 rx_full, bit 4 busy
    // IRQ_EN and IRQ_PEND hold an irq_vec_t in bits 2:0
    //   bit 2 tx_empty, bit 1 rx_full, bit 0 done (write 1 to clear)

    typedef struct packed {
        logic [7:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [7:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic                 empty;
        logic                 full;
        logic [MAX_CNT_W-1:0] count;
    } fifo_stat_t;

    typedef struct packed {
        logic tx_empty;
        logic rx_full;
        logic done;
    } irq_vec_t;

endpackage

// ==== verilog/spi_fifo.sv ====
// SPI word FIFO
module spi_fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  push,
    input  logic [DATA_WIDTH-1:0] push_data,
    input  logic                  pop,
    output logic [DATA_WIDTH-1:0] head,
    output spi_pkg::fifo_stat_t   stat
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [AW:0]           wr_ptr;
    logic [AW:0]           rd_ptr;
    logic [AW:0]           used;
    logic                  do_push;
    logic                  do_pop;

    // extra pointer bit separates full from empty
    assign used = wr_ptr - rd_ptr;

    assign stat.empty = (wr_ptr == rd_ptr);
    // used reaches FIFO_DEPTH only when its top bit is set
    assign stat.full  = used[AW];
    assign stat.count = {{(spi_pkg::MAX_CNT_W - AW - 1){1'b0}}, used};

    assign do_push = push && !stat.full;
    assign do_pop  = pop && !stat.empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_data;
        end
    end

    assign head = mem[rd_ptr[AW-1:0]];

    // producers and consumers look at the flags before acting
    push_not_full: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> !stat.full);

    pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> !stat.empty);

endmodule

// ==== verilog/spi_shift_engine.sv ====
// SPI mode 0 shift engine
module spi_shift_engine #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  spi_pkg::fifo_stat_t   tx_stat,
    input  spi_pkg::fifo_stat_t   rx_stat,
    input  logic [DATA_WIDTH-1:0] tx_head,
    output logic                  tx_pop,
    output logic                  rx_push,
    output logic [DATA_WIDTH-1:0] rx_word,
    output logic                  done,
    output logic                  busy,
    output logic                  sclk,
    output logic                  mosi,
    output logic                  cs_n,
    input  logic                  miso
);

    localparam int CW = (DATA_WIDTH > 1) ? $clog2(DATA_WIDTH) : 1;
    localparam logic [CW-1:0] LAST_BIT = CW'(DATA_WIDTH - 1);

    // one-hot states
    localparam logic [2:0] ST_IDLE  = 3'b001;
    localparam logic [2:0] ST_SHIFT = 3'b010;
    localparam logic [2:0] ST_GAP   = 3'b100;

    logic [2:0]            state;
    logic [CW-1:0]         bit_cnt;
    logic [DATA_WIDTH-1:0] tx_sh;
    logic [DATA_WIDTH-1:0] rx_sh;
    logic                  sclk_q;
    logic                  end_q;
    logic                  start;
    logic                  last_slot;

    // never start a word the RX FIFO could not take
    assign start     = state[0] && !tx_stat.empty && !rx_stat.full;
    assign last_slot = state[1] && sclk_q && (bit_cnt == LAST_BIT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            bit_cnt <= '0;
            sclk_q  <= 1'b0;
            cs_n    <= 1'b1;
            end_q   <= 1'b0;
        end else begin
            end_q <= 1'b0;
            case (1'b1)
                state[0]: begin
                    if (start) begin
                        state   <= ST_SHIFT;
                        cs_n    <= 1'b0;
                        bit_cnt <= '0;
                        sclk_q  <= 1'b0;
                    end
                end
                state[1]: begin
                    // low half then high half of each bit slot
                    sclk_q <= !sclk_q;
                    if (last_slot) begin
                        state <= ST_GAP;
                        cs_n  <= 1'b1;
                        end_q <= 1'b1;
                    end else if (sclk_q) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                state[2]: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state  <= ST_IDLE;
                    cs_n   <= 1'b1;
                    sclk_q <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            tx_sh <= tx_head;
        end else if (state[1] && sclk_q) begin
            tx_sh <= tx_sh << 1;
        end
        // sample on the rising sclk edge
        if (state[1] && !sclk_q) begin
            rx_sh <= DATA_WIDTH'({rx_sh, miso});
        end
    end

    assign sclk    = sclk_q;
    assign mosi    = state[1] & tx_sh[DATA_WIDTH-1];
    assign tx_pop  = end_q;
    assign rx_push = end_q;
    assign done    = end_q;
    assign rx_word = rx_sh;
    assign busy    = !state[0] || start;

    sclk_inside_cs: assert property (@(posedge clk) disable iff (!rst_n)
        sclk |-> !cs_n);

    // word retired from TX lands in RX, and RX had room for it
    pop_push_paired: assert property (@(posedge clk) disable iff (!rst_n)
        tx_pop |-> (rx_push && !rx_stat.full && !tx_stat.empty));

endmodule

// ==== verilog/spi_irq_ctrl.sv ====
// SPI interrupt controller
module spi_irq_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  spi_pkg::fifo_stat_t tx_stat,
    input  spi_pkg::fifo_stat_t rx_stat,
    input  logic                done,
    input  spi_pkg::irq_vec_t   irq_en,
    input  spi_pkg::irq_vec_t   pend_clr,
    output spi_pkg::irq_vec_t   pend,
    output logic                irq
);

    logic done_q;

    // sticky done, a new pulse wins over a clear in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else if (done) begin
            done_q <= 1'b1;
        end else if (pend_clr.done) begin
            done_q <= 1'b0;
        end
    end

    // fifo sources are plain levels
    assign pend.tx_empty = tx_stat.empty;
    assign pend.rx_full  = rx_stat.full;
    assign pend.done     = done_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq <= 1'b0;
        end else begin
            irq <= |(pend & irq_en);
        end
    end

    masked_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (irq_en == '0) |=> !irq);

endmodule

// ==== verilog/spi_axil_regs.sv ====
// AXI4-Lite register block
module spi_axil_regs #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  spi_pkg::axil_req_t    req,
    output spi_pkg::axil_rsp_t    rsp,
    output logic                  tx_push,
    output logic [DATA_WIDTH-1:0] tx_data,
    input  spi_pkg::fifo_stat_t   tx_stat,
    input  spi_pkg::fifo_stat_t   rx_stat,
    output logic                  rx_pop,
    input  logic [DATA_WIDTH-1:0] rx_head,
    input  logic                  busy,
    output spi_pkg::irq_vec_t     irq_en,
    output spi_pkg::irq_vec_t     pend_clr,
    input  spi_pkg::irq_vec_t     pend
);

    logic              wr_hs;
    logic              rd_hs;
    logic              bvalid_q;
    logic [1:0]        bresp_q;
    logic              arready_q;
    logic              rvalid_q;
    logic [1:0]        rresp_q;
    logic [31:0]       rdata_q;
    logic [1:0]        wr_resp;
    logic [1:0]        rd_resp;
    logic [31:0]       rd_data;
    spi_pkg::irq_vec_t irq_en_q;

    assign wr_hs = req.awvalid && req.wvalid && !bvalid_q;
    assign rd_hs = req.arvalid && arready_q;

    // wstrb is not decoded, every write is taken as a full word
    assign tx_data = req.wdata[DATA_WIDTH-1:0];

    always_comb begin
        wr_resp  = spi_pkg::RESP_OKAY;
        tx_push  = 1'b0;
        pend_clr = '0;
        case (req.awaddr)
            spi_pkg::REG_TXDATA: begin
                if (tx_stat.full) begin
                    wr_resp = spi_pkg::RESP_SLVERR;
                end else begin
                    tx_push = wr_hs;
                end
            end
            spi_pkg::REG_IRQ_PEND: begin
                if (wr_hs) begin
                    pend_clr = req.wdata[2:0];
                end
            end
            // read-only and enable writes answer OKAY
            spi_pkg::REG_RXDATA, spi_pkg::REG_STATUS, spi_pkg::REG_IRQ_EN: begin
                wr_resp = spi_pkg::RESP_OKAY;
            end
            default: begin
                wr_resp = spi_pkg::RESP_SLVERR;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_en_q <= '0;
        end else if (wr_hs && req.awaddr == spi_pkg::REG_IRQ_EN) begin
            irq_en_q <= req.wdata[2:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid_q <= 1'b0;
            bresp_q  <= spi_pkg::RESP_OKAY;
        end else if (wr_hs) begin
            bvalid_q <= 1'b1;
            bresp_q  <= wr_resp;
        end else if (req.bready) begin
            bvalid_q <= 1'b0;
        end
    end

    always_comb begin
        rd_data = '0;
        rd_resp = spi_pkg::RESP_OKAY;
        rx_pop  = 1'b0;
        case (req.araddr)
            spi_pkg::REG_TXDATA: begin
                rd_data = '0;
            end
            spi_pkg::REG_RXDATA: begin
                // empty FIFO reads zero and is not popped
                if (rx_stat.empty) begin
                    rd_resp = spi_pkg::RESP_SLVERR;
                end else begin
                    rd_data = 32'(rx_head);
                    rx_pop  = rd_hs;
                end
            end
            spi_pkg::REG_STATUS: begin
                rd_data = {27'b0, busy, rx_stat.full, rx_stat.empty,
                           tx_stat.full, tx_stat.empty};
            end
            spi_pkg::REG_IRQ_EN: begin
                rd_data = {29'b0, irq_en_q};
            end
            spi_pkg::REG_IRQ_PEND: begin
                rd_data = {29'b0, pend};
            end
            default: begin
                rd_resp = spi_pkg::RESP_SLVERR;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
            rresp_q   <= spi_pkg::RESP_OKAY;
        end else if (rd_hs) begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b1;
            rresp_q   <= rd_resp;
        end else if (rvalid_q && req.rready) begin
            rvalid_q  <= 1'b0;
            arready_q <= 1'b1;
        end else if (!rvalid_q) begin
            arready_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rdata_q <= rd_data;
        end
    end

    assign rsp.awready = wr_hs;
    assign rsp.wready  = wr_hs;
    assign rsp.bvalid  = bvalid_q;
    assign rsp.bresp   = bresp_q;
    assign rsp.arready = arready_q;
    assign rsp.rvalid  = rvalid_q;
    assign rsp.rdata   = rdata_q;
    assign rsp.rresp   = rresp_q;
    assign irq_en      = irq_en_q;

    bvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp.bvalid && !req.bready) |=> (rsp.bvalid && $stable(rsp.bresp)));

endmodule

// ==== verilog/spi_irq_top.sv ====
// SPI master with interrupts
module spi_irq_top #(
    parameter int DATA_WIDTH = 8,
    parameter int FIFO_DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  spi_pkg::axil_req_t axil_req,
    output spi_pkg::axil_rsp_t axil_rsp,
    output logic               sclk,
    output logic               mosi,
    input  logic               miso,
    output logic               cs_n,
    output logic               irq
);

    logic                  tx_push;
    logic [DATA_WIDTH-1:0] tx_data;
    logic [DATA_WIDTH-1:0] tx_head;
    logic                  tx_pop;
    spi_pkg::fifo_stat_t   tx_stat;
    logic                  rx_push;
    logic [DATA_WIDTH-1:0] rx_word;
    logic [DATA_WIDTH-1:0] rx_head;
    logic                  rx_pop;
    spi_pkg::fifo_stat_t   rx_stat;
    logic                  busy;
    logic                  done;
    spi_pkg::irq_vec_t     irq_en;
    spi_pkg::irq_vec_t     pend_clr;
    spi_pkg::irq_vec_t     pend;

    spi_axil_regs #(.DATA_WIDTH(DATA_WIDTH)) u_regs (
        .clk(clk), .rst_n(rst_n), .req(axil_req), .rsp(axil_rsp),
        .tx_push(tx_push), .tx_data(tx_data), .tx_stat(tx_stat), .rx_stat(rx_stat),
        .rx_pop(rx_pop), .rx_head(rx_head), .busy(busy),
        .irq_en(irq_en), .pend_clr(pend_clr), .pend(pend)
    );

    spi_fifo #(.DATA_WIDTH(DATA_WIDTH), .FIFO_DEPTH(FIFO_DEPTH)) u_tx_fifo (
        .clk(clk), .rst_n(rst_n), .push(tx_push), .push_data(tx_data),
        .pop(tx_pop), .head(tx_head), .stat(tx_stat)
    );

    spi_fifo #(.DATA_WIDTH(DATA_WIDTH), .FIFO_DEPTH(FIFO_DEPTH)) u_rx_fifo (
        .clk(clk), .rst_n(rst_n), .push(rx_push), .push_data(rx_word),
        .pop(rx_pop), .head(rx_head), .stat(rx_stat)
    );

    spi_shift_engine #(.DATA_WIDTH(DATA_WIDTH)) u_engine (
        .clk(clk), .rst_n(rst_n), .tx_stat(tx_stat), .rx_stat(rx_stat),
        .tx_head(tx_head), .tx_pop(tx_pop), .rx_push(rx_push), .rx_word(rx_word),
        .done(done), .busy(busy), .sclk(sclk), .mosi(mosi), .cs_n(cs_n), .miso(miso)
    );

    spi_irq_ctrl u_irq (
        .clk(clk), .rst_n(rst_n), .tx_stat(tx_stat), .rx_stat(rx_stat),
        .done(done), .irq_en(irq_en), .pend_clr(pend_clr), .pend(pend), .irq(irq)
    );

endmodule

// ==== verification/tb_spi_irq.sv ====
// SPI controller testbench
module tb_spi_irq;

    localparam int CLK_PERIOD  = 40;
    localparam int DRV_DLY     = 5;
    localparam int POLL_LIMIT  = 60;
    localparam int STEP_CYCLES = 200;
    localparam int WORD_BITS   = 8;
    localparam logic [31:0] LFSR_SEED = 32'h73cadd04;

    localparam logic [1:0]  OKAY   = spi_pkg::RESP_OKAY;
    localparam logic [1:0]  SLVERR = spi_pkg::RESP_SLVERR;
    localparam logic [31:0] ALL    = 32'hffff_ffff;
    // STATUS values for idle, for a held RX FIFO and the busy bit
    localparam logic [31:0] STAT_IDLE   = 32'h0000_0005;
    localparam logic [31:0] STAT_RX_HELD = 32'h0000_0008;
    localparam logic [31:0] BUSY_BIT    = 32'h0000_0010;
    localparam logic [7:0]  UNMAPPED    = 8'h14;

    // table operations
    localparam logic [3:0] OP_WR     = 4'd0;
    localparam logic [3:0] OP_BURST  = 4'd1;
    localparam logic [3:0] OP_BCHK   = 4'd2;
    localparam logic [3:0] OP_RD     = 4'd3;
    localparam logic [3:0] OP_RD_VEC = 4'd4;
    localparam logic [3:0] OP_RD_SB  = 4'd5;
    localparam logic [3:0] OP_POLL   = 4'd6;
    localparam logic [3:0] OP_IRQ    = 4'd7;
    localparam logic [3:0] OP_DRAIN  = 4'd8;

    typedef struct packed {
        logic [3:0]  op;
        logic [7:0]  addr;
        logic [31:0] data;
        logic [1:0]  resp;
        logic [31:0] exp;
        logic [31:0] mask;
    } step_t;

    logic               clk;
    logic               rst_n;
    spi_pkg::axil_req_t req;
    spi_pkg::axil_rsp_t rsp;
    logic               sclk;
    logic               mosi;
    logic               miso;
    logic               cs_n;
    logic               irq;

    step_t       steps[$];
    logic [31:0] sent_q[$];
    logic [31:0] lfsr;
    logic        table_ready;
    int          err_count;
    int          check_count;
    int          fail_steps;
    int          burst_accepts;
    int          burst_rejects;
    string       note;
    int          frame_edges;
    logic        sclk_prev;
    logic        cs_prev;

    // loopback
    assign miso = mosi;

    spi_irq_top #(.DATA_WIDTH(WORD_BITS), .FIFO_DEPTH(4)) u_dut (
        .clk(clk), .rst_n(rst_n), .axil_req(req), .axil_rsp(rsp),
        .sclk(sclk), .mosi(mosi), .miso(miso), .cs_n(cs_n), .irq(irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // one LFSR step per data bit
    function automatic logic [31:0] rand_word();
        logic [7:0] w;
        w = '0;
        for (int i = 0; i < 8; i++) begin
            w = {w[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return {24'b0, w};
    endfunction

    // irq level as the enable rule gives it
    function automatic logic irq_from(input spi_pkg::irq_vec_t pend,
                                      input spi_pkg::irq_vec_t en);
        return |(pend & en);
    endfunction

    function automatic string op_name(input logic [3:0] op);
        case (op)
            OP_WR:     return "write";
            OP_BURST:  return "burst";
            OP_BCHK:   return "count";
            OP_RD:     return "read";
            OP_RD_VEC: return "pend";
            OP_RD_SB:  return "rxword";
            OP_POLL:   return "poll";
            OP_IRQ:    return "irq";
            OP_DRAIN:  return "drain";
            default:   return "?";
        endcase
    endfunction

    function automatic void add_step(input logic [3:0] op, input logic [7:0] addr,
                                     input logic [31:0] data, input logic [1:0] resp,
                                     input logic [31:0] exp, input logic [31:0] mask);
        step_t s;
        s.op   = op;
        s.addr = addr;
        s.data = data;
        s.resp = resp;
        s.exp  = exp;
        s.mask = mask;
        steps.push_back(s);
    endfunction

    function automatic void build_table();
        spi_pkg::irq_vec_t idle_pend;
        spi_pkg::irq_vec_t done_pend;
        spi_pkg::irq_vec_t en;
        idle_pend = '{tx_empty: 1'b1, rx_full: 1'b0, done: 1'b0};
        done_pend = '{tx_empty: 1'b1, rx_full: 1'b0, done: 1'b1};
        // reset values
        add_step(OP_RD, spi_pkg::REG_STATUS, '0, OKAY, STAT_IDLE, ALL);
        add_step(OP_RD, spi_pkg::REG_IRQ_EN, '0, OKAY, '0, ALL);
        add_step(OP_RD_VEC, spi_pkg::REG_IRQ_PEND, '0, OKAY, {29'b0, idle_pend}, ALL);
        add_step(OP_IRQ, '0, '0, OKAY, '0, ALL);
        // loopback of four words
        for (int i = 0; i < 4; i++) begin
            add_step(OP_WR, spi_pkg::REG_TXDATA, rand_word(), OKAY, '0, ALL);
        end
        add_step(OP_POLL, spi_pkg::REG_STATUS, '0, OKAY, '0, BUSY_BIT);
        for (int i = 0; i < 4; i++) begin
            add_step(OP_RD_SB, spi_pkg::REG_RXDATA, '0, OKAY, '0, ALL);
        end
        add_step(OP_RD, spi_pkg::REG_STATUS, '0, OKAY, STAT_IDLE, ALL);
        // fifo limits
        for (int i = 0; i < 5; i++) begin
            add_step(OP_BURST, spi_pkg::REG_TXDATA, rand_word(), OKAY, '0, ALL);
        end
        add_step(OP_BCHK, '0, '0, OKAY, '0, ALL);
        add_step(OP_POLL, spi_pkg::REG_STATUS, '0, OKAY, STAT_RX_HELD, STAT_RX_HELD);
        add_step(OP_WR, spi_pkg::REG_TXDATA, rand_word(), OKAY, '0, ALL);
        add_step(OP_RD, spi_pkg::REG_STATUS, '0, OKAY, STAT_RX_HELD, ALL);
        add_step(OP_DRAIN, spi_pkg::REG_RXDATA, '0, OKAY, '0, ALL);
        add_step(OP_RD, spi_pkg::REG_RXDATA, '0, SLVERR, '0, ALL);
        // interrupts
        add_step(OP_WR, spi_pkg::REG_IRQ_PEND, 32'h1, OKAY, '0, ALL);
        add_step(OP_RD_VEC, spi_pkg::REG_IRQ_PEND, '0, OKAY, {29'b0, idle_pend}, ALL);
        en = '{tx_empty: 1'b0, rx_full: 1'b0, done: 1'b1};
        add_step(OP_WR, spi_pkg::REG_IRQ_EN, {29'b0, en}, OKAY, '0, ALL);
        add_step(OP_RD, spi_pkg::REG_IRQ_EN, '0, OKAY, {29'b0, en}, ALL);
        add_step(OP_IRQ, '0, '0, OKAY, {31'b0, irq_from(idle_pend, en)}, ALL);
        add_step(OP_WR, spi_pkg::REG_TXDATA, rand_word(), OKAY, '0, ALL);
        add_step(OP_POLL, spi_pkg::REG_STATUS, '0, OKAY, '0, BUSY_BIT);
        add_step(OP_IRQ, '0, '0, OKAY, {31'b0, irq_from(done_pend, en)}, ALL);
        add_step(OP_RD_VEC, spi_pkg::REG_IRQ_PEND, '0, OKAY, {29'b0, done_pend}, ALL);
        add_step(OP_WR, spi_pkg::REG_IRQ_PEND, 32'h1, OKAY, '0, ALL);
        add_step(OP_IRQ, '0, '0, OKAY, {31'b0, irq_from(idle_pend, en)}, ALL);
        // tx_empty level keeps irq up once enabled
        en = '{tx_empty: 1'b1, rx_full: 1'b0, done: 1'b1};
        add_step(OP_WR, spi_pkg::REG_IRQ_EN, {29'b0, en}, OKAY, '0, ALL);
        add_step(OP_IRQ, '0, '0, OKAY, {31'b0, irq_from(idle_pend, en)}, ALL);
        en = '0;
        add_step(OP_WR, spi_pkg::REG_IRQ_EN, {29'b0, en}, OKAY, '0, ALL);
        add_step(OP_IRQ, '0, '0, OKAY, {31'b0, irq_from(idle_pend, en)}, ALL);
        add_step(OP_RD_SB, spi_pkg::REG_RXDATA, '0, OKAY, '0, ALL);
        // unmapped address
        add_step(OP_WR, spi_pkg::REG_IRQ_EN, 32'h2, OKAY, '0, ALL);
        add_step(OP_WR, UNMAPPED, ALL, SLVERR, '0, ALL);
        add_step(OP_RD, UNMAPPED, '0, SLVERR, '0, ALL);
        add_step(OP_RD, spi_pkg::REG_IRQ_EN, '0, OKAY, 32'h2, ALL);
        add_step(OP_RD, spi_pkg::REG_STATUS, '0, OKAY, STAT_IDLE, ALL);
    endfunction

    task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("Mismatch at %0t: %s expected %0d, actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_data(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("Mismatch at %0t: %s expected 0x%08h, actual 0x%08h",
                     $time, name, exp, act);
        end
    endtask

    task automatic check_irq_vec(input string name, input spi_pkg::irq_vec_t exp,
                                 input spi_pkg::irq_vec_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("Mismatch at %0t: %s expected %b, actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("Mismatch at %0t: %s expected %b, actual %b", $time, name, exp, act);
        end
    endtask

    // called and left a drive delay after a rising edge
    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        req.awaddr  = addr;
        req.awvalid = 1'b1;
        req.wdata   = data;
        req.wstrb   = 4'hf;
        req.wvalid  = 1'b1;
        req.bready  = 1'b1;
        @(negedge clk);
        while (!rsp.awready) @(negedge clk);
        @(posedge clk);
        #DRV_DLY;
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        @(negedge clk);
        while (!rsp.bvalid) @(negedge clk);
        resp = rsp.bresp;
        @(posedge clk);
        #DRV_DLY;
        req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        req.araddr  = addr;
        req.arvalid = 1'b1;
        req.rready  = 1'b1;
        @(negedge clk);
        while (!rsp.arready) @(negedge clk);
        @(posedge clk);
        #DRV_DLY;
        req.arvalid = 1'b0;
        @(negedge clk);
        while (!rsp.rvalid) @(negedge clk);
        data = rsp.rdata;
        resp = rsp.rresp;
        @(posedge clk);
        #DRV_DLY;
        req.rready = 1'b0;
    endtask

    task automatic poll_reg(input logic [7:0] addr, input logic [31:0] mask,
                            input logic [31:0] exp);
        logic [31:0] data;
        logic [1:0]  resp;
        int          polls;
        polls = 1;
        axil_read(addr, data, resp);
        while (((data & mask) != exp) && polls < POLL_LIMIT) begin
            polls++;
            axil_read(addr, data, resp);
        end
        if ((data & mask) != exp) begin
            err_count++;
            $display("Register 0x%02h never reached 0x%08h under mask 0x%08h in %0d reads",
                     addr, exp, mask, polls);
        end
    endtask

    // RXDATA against the accepted words in order
    task automatic read_sent_word();
        logic [31:0] data;
        logic [31:0] exp;
        logic [1:0]  resp;
        if (sent_q.size() == 0) begin
            err_count++;
            $display("At %0t an RXDATA read had no accepted word left to compare", $time);
        end else begin
            exp = sent_q.pop_front();
            axil_read(spi_pkg::REG_RXDATA, data, resp);
            check_resp("rresp", OKAY, resp);
            check_data("rdata", exp, data);
        end
    endtask

    task automatic run_step(input step_t s);
        logic [31:0] data;
        logic [1:0]  resp;
        note = "";
        case (s.op)
            OP_WR: begin
                axil_write(s.addr, s.data, resp);
                check_resp("bresp", s.resp, resp);
                if (s.addr == spi_pkg::REG_TXDATA && s.resp == OKAY) begin
                    sent_q.push_back(s.data);
                end
            end
            OP_BURST: begin
                axil_write(s.addr, s.data, resp);
                if (resp == OKAY) begin
                    burst_accepts++;
                    sent_q.push_back(s.data);
                end else begin
                    burst_rejects++;
                end
            end
            OP_BCHK: begin
                note = $sformatf("%0d accepted, %0d rejected", burst_accepts, burst_rejects);
                if (burst_rejects > 1) begin
                    err_count++;
                    $display("Burst of writes had %0d rejected words, one at most allowed",
                             burst_rejects);
                end
            end
            OP_RD: begin
                axil_read(s.addr, data, resp);
                check_resp("rresp", s.resp, resp);
                check_data("rdata", s.exp, data & s.mask);
            end
            OP_RD_VEC: begin
                axil_read(s.addr, data, resp);
                check_resp("rresp", s.resp, resp);
                check_irq_vec("irq_pend", s.exp[2:0], data[2:0]);
            end
            OP_RD_SB: read_sent_word();
            OP_POLL:  poll_reg(s.addr, s.mask, s.exp);
            OP_IRQ: begin
                @(negedge clk);
                check_level("irq", s.exp[0], irq);
                // engine is idle here, so the SPI pins rest
                check_level("cs_n", 1'b1, cs_n);
                check_level("sclk", 1'b0, sclk);
                @(posedge clk);
                #DRV_DLY;
            end
            OP_DRAIN: begin
                while (sent_q.size() > 0) begin
                    poll_reg(spi_pkg::REG_STATUS, BUSY_BIT, '0);
                    read_sent_word();
                end
            end
            default: begin
                err_count++;
                $display("Table holds an unknown operation %0d", s.op);
            end
        endcase
    endtask

    // one sclk pulse per data bit inside each chip-select frame
    always @(negedge clk) begin
        if (rst_n) begin
            if (cs_prev && !cs_n) begin
                frame_edges = 0;
            end
            if (sclk && !sclk_prev) begin
                frame_edges++;
            end
            if (sclk && cs_n) begin
                err_count++;
                $display("At %0t sclk was high while cs_n was high", $time);
            end
            if (!cs_prev && cs_n) begin
                check_count++;
                if (frame_edges != WORD_BITS) begin
                    err_count++;
                    $display("Mismatch at %0t: sclk pulses expected %0d, actual %0d",
                             $time, WORD_BITS, frame_edges);
                end
            end
        end
        sclk_prev = sclk;
        cs_prev   = cs_n;
    end

    initial begin
        int errs_before;
        rst_n         = 1'b0;
        req           = '0;
        lfsr          = LFSR_SEED;
        err_count     = 0;
        check_count   = 0;
        fail_steps    = 0;
        burst_accepts = 0;
        burst_rejects = 0;
        frame_edges   = 0;
        sclk_prev     = 1'b0;
        cs_prev       = 1'b1;
        table_ready   = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        #DRV_DLY;
        rst_n = 1'b1;
        @(posedge clk);
        #DRV_DLY;
        foreach (steps[i]) begin
            errs_before = err_count;
            run_step(steps[i]);
            if (err_count != errs_before) begin
                fail_steps++;
            end
            $display("step %0d %s addr 0x%02h %s %s", i + 1, op_name(steps[i].op),
                     steps[i].addr, (err_count == errs_before) ? "ok" : "failed", note);
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 steps.size(), fail_steps, check_count, err_count);
        if (err_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // run length scales with the table
    initial begin
        wait (table_ready);
        #(steps.size() * STEP_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not complete",
                 steps.size() * STEP_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== tb.f ====
verilog/spi_pkg.sv
verilog/spi_fifo.sv
verilog/spi_shift_engine.sv
verilog/spi_irq_ctrl.sv
verilog/spi_axil_regs.sv
verilog/spi_irq_top.sv
verification/tb_spi_irq.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_spi_irq
FLIST     ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
